// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic              clk,
    input  logic              reset,
    input  rvPipe_pkg::ifIdT  i_ifId,
    output rvIsa_pkg::regIdxT o_rs1,
    output rvIsa_pkg::regIdxT o_rs2,
    input  rvIsa_pkg::wordT   i_rdata1,
    input  rvIsa_pkg::wordT   i_rdata2,
    output logic              o_stall,
    output rvPipe_pkg::idExT  o_idEx
);

    rvIsa_pkg::opcodeT opcode;
    rvIsa_pkg::funct3T funct3;
    rvIsa_pkg::regIdxT rs1;
    rvIsa_pkg::regIdxT rs2;
    rvIsa_pkg::regIdxT rd;
    rvIsa_pkg::wordT   immI;
    rvIsa_pkg::wordT   immS;
    rvIsa_pkg::wordT   imm;
    rvIsa_pkg::ctrlT   ctrl;
    rvIsa_pkg::aluOpT  fnOp;
    logic              fnOk;
    logic              known;
    logic              usesRs2;
    logic              rawHit;
    rvPipe_pkg::idExT  idEx;

    assign opcode = i_ifId.instr[6:0];
    assign rd     = i_ifId.instr[11:7];
    assign funct3 = i_ifId.instr[14:12];
    assign rs1    = i_ifId.instr[19:15];
    assign rs2    = i_ifId.instr[24:20];

    assign immI = {{20{i_ifId.instr[31]}}, i_ifId.instr[31:20]};
    assign immS = {{20{i_ifId.instr[31]}}, i_ifId.instr[31:25], i_ifId.instr[11:7]};

    // ALU function shared by register and immediate forms
    always_comb begin
        fnOk = 1'b1;
        case (funct3)
            rvIsa_pkg::F3_ADD: fnOp = rvIsa_pkg::ALU_ADD;
            rvIsa_pkg::F3_SLT: fnOp = rvIsa_pkg::ALU_SLT;
            rvIsa_pkg::F3_XOR: fnOp = rvIsa_pkg::ALU_XOR;
            rvIsa_pkg::F3_OR:  fnOp = rvIsa_pkg::ALU_OR;
            rvIsa_pkg::F3_AND: fnOp = rvIsa_pkg::ALU_AND;
            default: begin
                fnOp = rvIsa_pkg::ALU_ADD;
                fnOk = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl    = '0;
        known   = 1'b0;
        usesRs2 = 1'b0;
        imm     = immI;
        case (opcode)
            rvIsa_pkg::OP_REG: begin
                known         = fnOk;
                usesRs2       = 1'b1;
                ctrl.regWrite = 1'b1;
                // funct7 bit 5 turns ADD into SUB
                if ((funct3 == rvIsa_pkg::F3_ADD) && i_ifId.instr[30]) begin
                    ctrl.aluOp = rvIsa_pkg::ALU_SUB;
                end else begin
                    ctrl.aluOp = fnOp;
                end
            end
            rvIsa_pkg::OP_IMM: begin
                known         = fnOk;
                ctrl.aluOp    = fnOp;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            rvIsa_pkg::OP_LOAD: begin
                known         = (funct3 == rvIsa_pkg::F3_WORD);
                ctrl.aluOp    = rvIsa_pkg::ALU_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            rvIsa_pkg::OP_STORE: begin
                known         = (funct3 == rvIsa_pkg::F3_WORD);
                usesRs2       = 1'b1;
                imm           = immS;
                ctrl.aluOp    = rvIsa_pkg::ALU_ADD;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // Load in ID/EX whose result the next instruction needs
    assign rawHit  = (idEx.rd == rs1) || (usesRs2 && (idEx.rd == rs2));
    assign o_stall = i_ifId.valid && known && idEx.valid && idEx.ctrl.memRead
                     && (idEx.rd != '0) && rawHit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idEx <= '0;
        end else begin
            // Stalled or unsupported instructions leave a bubble
            idEx.valid <= i_ifId.valid && known && !o_stall;
            idEx.ctrl  <= ctrl;
            idEx.rs1   <= rs1;
            idEx.rs2   <= rs2;
            idEx.rd    <= rd;
            idEx.op1   <= i_rdata1;
            idEx.op2   <= i_rdata2;
            idEx.imm   <= imm;
        end
    end

    assign o_rs1  = rs1;
    assign o_rs2  = rs2;
    assign o_idEx = idEx;

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic              clk,
    input  logic              reset,
    input  rvPipe_pkg::idExT  i_idEx,
    input  rvPipe_pkg::wbT    i_wb,
    output rvPipe_pkg::exMemT o_exMem
);

    rvPipe_pkg::exMemT exMem;
    rvIsa_pkg::wordT   rs1Val;
    rvIsa_pkg::wordT   rs2Val;
    rvIsa_pkg::wordT   aluB;
    rvIsa_pkg::wordT   aluResult;

    function automatic logic fwdHit(
        input logic              srcValid,
        input logic              srcRegWrite,
        input rvIsa_pkg::regIdxT srcRd,
        input rvIsa_pkg::regIdxT rs
    );
        return srcValid && srcRegWrite && (srcRd != '0) && (srcRd == rs);
    endfunction

    // Youngest producer wins, so EX/MEM is checked before writeback
    always_comb begin
        if (fwdHit(exMem.valid, exMem.regWrite, exMem.rd, i_idEx.rs1)) begin
            rs1Val = exMem.aluResult;
        end else if (fwdHit(i_wb.valid, i_wb.regWrite, i_wb.rd, i_idEx.rs1)) begin
            rs1Val = i_wb.value;
        end else begin
            rs1Val = i_idEx.op1;
        end

        if (fwdHit(exMem.valid, exMem.regWrite, exMem.rd, i_idEx.rs2)) begin
            rs2Val = exMem.aluResult;
        end else if (fwdHit(i_wb.valid, i_wb.regWrite, i_wb.rd, i_idEx.rs2)) begin
            rs2Val = i_wb.value;
        end else begin
            rs2Val = i_idEx.op2;
        end
    end

    assign aluB = i_idEx.ctrl.aluSrc ? i_idEx.imm : rs2Val;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            rvIsa_pkg::ALU_ADD: aluResult = rs1Val + aluB;
            rvIsa_pkg::ALU_SUB: aluResult = rs1Val - aluB;
            rvIsa_pkg::ALU_AND: aluResult = rs1Val & aluB;
            rvIsa_pkg::ALU_OR:  aluResult = rs1Val | aluB;
            rvIsa_pkg::ALU_XOR: aluResult = rs1Val ^ aluB;
            // Signed compare for SLT and SLTI
            rvIsa_pkg::ALU_SLT: aluResult = {31'd0, $signed(rs1Val) < $signed(aluB)};
            default:            aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= i_idEx.valid;
            exMem.regWrite  <= i_idEx.ctrl.regWrite;
            exMem.memRead   <= i_idEx.ctrl.memRead;
            exMem.memWrite  <= i_idEx.ctrl.memWrite;
            exMem.rd        <= i_idEx.rd;
            exMem.aluResult <= aluResult;
            exMem.storeData <= rs2Val;
        end
    end

    assign o_exMem = exMem;

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
    parameter int IMEM_ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_run,
    input  rvPipe_pkg::progLoadT i_progLoad,
    input  logic                 i_stall,
    output rvPipe_pkg::ifIdT     o_ifId
);

    typedef logic [IMEM_ADDR_BITS-1:0] imemIdxT;

    rvIsa_pkg::wordT  imem [2**IMEM_ADDR_BITS];
    rvIsa_pkg::wordT  pc;
    rvPipe_pkg::ifIdT ifId;

    imemIdxT pcIdx;
    imemIdxT loadIdx;

    assign pcIdx   = pc[IMEM_ADDR_BITS+1:2];
    assign loadIdx = i_progLoad.addr[IMEM_ADDR_BITS-1:0];

    // Program load only while the core is halted
    always_ff @(posedge clk) begin
        if (i_progLoad.we && !i_run) begin
            imem[loadIdx] <= i_progLoad.data;
        end
    end

    // PC and IF/ID both freeze on a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!i_stall) begin
            if (i_run) begin
                ifId.valid <= 1'b1;
                ifId.pc    <= pc;
                ifId.instr <= imem[pcIdx];
                pc         <= pc + 32'd4;
            end else begin
                // Halted, so older instructions drain behind empty slots
                ifId.valid <= 1'b0;
            end
        end
    end

    assign o_ifId = ifId;

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
    parameter int DMEM_ADDR_BITS = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  rvPipe_pkg::exMemT  i_exMem,
    output rvPipe_pkg::wbT     o_wb,
    output rvPipe_pkg::retireT o_retire
);

    typedef logic [DMEM_ADDR_BITS-1:0] dmemIdxT;

    rvIsa_pkg::wordT dmem [2**DMEM_ADDR_BITS];
    dmemIdxT         memIdx;
    rvIsa_pkg::wordT loadData;
    rvIsa_pkg::wordT result;
    rvPipe_pkg::wbT  wb;

    // Word index, the low two address bits are ignored
    assign memIdx   = i_exMem.aluResult[DMEM_ADDR_BITS+1:2];
    assign loadData = dmem[memIdx];
    assign result   = i_exMem.memRead ? loadData : i_exMem.aluResult;

    always_ff @(posedge clk) begin
        if (i_exMem.valid && i_exMem.memWrite) begin
            dmem[memIdx] <= i_exMem.storeData;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid    <= i_exMem.valid;
            wb.regWrite <= i_exMem.regWrite;
            wb.rd       <= i_exMem.rd;
            wb.value    <= result;
        end
    end

    assign o_wb = wb;

    // Only committed writes to a real register are reported
    assign o_retire.valid = wb.valid && wb.regWrite && (wb.rd != '0);
    assign o_retire.rd    = wb.rd;
    assign o_retire.value = wb.value;

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  rvIsa_pkg::regIdxT i_rs1,
    input  rvIsa_pkg::regIdxT i_rs2,
    input  rvPipe_pkg::wbT    i_wb,
    output rvIsa_pkg::wordT   o_rdata1,
    output rvIsa_pkg::wordT   o_rdata2
);

    rvIsa_pkg::wordT regs [32];

    logic wrEn;

    assign wrEn = i_wb.valid && i_wb.regWrite && (i_wb.rd != '0);

    // x0 reads zero, a write in flight to the same index is passed through
    function automatic rvIsa_pkg::wordT readPort(
        input rvIsa_pkg::regIdxT idx,
        input rvIsa_pkg::wordT   stored,
        input logic              wen,
        input rvPipe_pkg::wbT    wb
    );
        rvIsa_pkg::wordT result;
        if (idx == '0) begin
            result = '0;
        end else if (wen && (wb.rd == idx)) begin
            result = wb.value;
        end else begin
            result = stored;
        end
        return result;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[i_wb.rd] <= i_wb.value;
        end
    end

    assign o_rdata1 = readPort(i_rs1, regs[i_rs1], wrEn, i_wb);
    assign o_rdata2 = readPort(i_rs2, regs[i_rs2], wrEn, i_wb);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rvCore_tb -Mdir obj_dir -f rvCore.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/VrvCore_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: rvCore.f
rvIsa_pkg.sv
rvPipe_pkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
rvCore.sv
rvCore_chk.sv
rvCore_tb.sv

// File: rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int IMEM_ADDR_BITS = 8,
    parameter int DMEM_ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_run,
    input  rvPipe_pkg::progLoadT i_progLoad,
    output rvPipe_pkg::retireT   o_retire
);

    rvPipe_pkg::ifIdT  ifId;
    rvPipe_pkg::idExT  idEx;
    rvPipe_pkg::exMemT exMem;
    rvPipe_pkg::wbT    wb;
    rvIsa_pkg::regIdxT rs1;
    rvIsa_pkg::regIdxT rs2;
    rvIsa_pkg::wordT   rdata1;
    rvIsa_pkg::wordT   rdata2;
    logic              stall;

    fetchStage #(
        .IMEM_ADDR_BITS(IMEM_ADDR_BITS)
    ) uFetch (
        .clk        (clk),
        .reset      (reset),
        .i_run      (i_run),
        .i_progLoad (i_progLoad),
        .i_stall    (stall),
        .o_ifId     (ifId)
    );

    regFile uRegFile (
        .clk      (clk),
        .reset    (reset),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_wb     (wb),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    decodeStage uDecode (
        .clk      (clk),
        .reset    (reset),
        .i_ifId   (ifId),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .i_rdata1 (rdata1),
        .i_rdata2 (rdata2),
        .o_stall  (stall),
        .o_idEx   (idEx)
    );

    executeStage uExecute (
        .clk     (clk),
        .reset   (reset),
        .i_idEx  (idEx),
        .i_wb    (wb),
        .o_exMem (exMem)
    );

    memoryStage #(
        .DMEM_ADDR_BITS(DMEM_ADDR_BITS)
    ) uMemory (
        .clk      (clk),
        .reset    (reset),
        .i_exMem  (exMem),
        .o_wb     (wb),
        .o_retire (o_retire)
    );

endmodule

// File: rvCore_chk.sv
`timescale 1ns/1ps

module rvCore_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 i_run,
    input rvPipe_pkg::progLoadT i_progLoad,
    input rvPipe_pkg::retireT   i_retire
);

    // Retire port stays quiet while held in reset
    retireQuietInReset: assert property (
        @(posedge clk) reset |-> !i_retire.valid
    ) else $error("o_retire.valid is high during reset");

    retireNeverX0: assert property (
        @(posedge clk) disable iff (reset) i_retire.valid |-> (i_retire.rd != '0)
    ) else $error("o_retire reports a write to x0");

    // Instruction memory is written only while halted
    loadOnlyWhenHalted: assert property (
        @(posedge clk) disable iff (reset) i_progLoad.we |-> !i_run
    ) else $error("program load strobe while i_run is high");

endmodule

bind rvCore rvCore_chk uChk (
    .clk        (clk),
    .reset      (reset),
    .i_run      (i_run),
    .i_progLoad (i_progLoad),
    .i_retire   (o_retire)
);

// File: rvCore_tb.sv
`timescale 1ns/1ps

module rvCore_tb;

    localparam int MAX_WAIT    = 200;
    localparam int PAUSE_GROUP = 6;

    logic                 clk;
    logic                 reset;
    logic                 run;
    rvPipe_pkg::progLoadT progLoad;
    rvPipe_pkg::retireT   retire;

    // Expected retires in program order, with the test group of each
    rvIsa_pkg::regIdxT expRd[$];
    rvIsa_pkg::wordT   expVal[$];
    int                expGrp[$];

    int groupErr[7];
    int pauseAt;
    int retireCount;
    int errorCount;
    int checkCount;
    int testsPassed;
    int testsFailed;
    bit aborted;

    rvCore DUT (
        .clk        (clk),
        .reset      (reset),
        .i_run      (run),
        .i_progLoad (progLoad),
        .o_retire   (retire)
    );

    always #2 clk = ~clk;

    function automatic string groupName(input int grp);
        case (grp)
            1: return "R-type results";
            2: return "immediate forms";
            3: return "forwarding";
            4: return "memory and load-use";
            5: return "x0 and bubbles";
            6: return "run pause";
            default: return "unknown";
        endcase
    endfunction

    task automatic reportGroup(input int grp);
        if (groupErr[grp] == 0) begin
            testsPassed++;
            $display("Test %0d %s: passed", grp, groupName(grp));
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", grp, groupName(grp), groupErr[grp]);
        end
    endtask

    // Compare one retire against the next expected entry
    task automatic checkRetire();
        int grp;
        if (retireCount >= expRd.size()) begin
            $display("Error at %0t: retire of x%0d with no expected entry left", $time, retire.rd);
            errorCount++;
        end else begin
            grp = expGrp[retireCount];
            checkCount++;
            if (retire.rd != expRd[retireCount]) begin
                $display("Mismatch at %0t: o_retire.rd expected %0d, got %0d",
                         $time, expRd[retireCount], retire.rd);
                errorCount++;
                groupErr[grp]++;
            end
            checkCount++;
            if (retire.value != expVal[retireCount]) begin
                $display("Mismatch at %0t: o_retire.value expected %h, got %h",
                         $time, expVal[retireCount], retire.value);
                errorCount++;
                groupErr[grp]++;
            end
            retireCount++;
            // Last entry of a group closes that test
            if (retireCount == expRd.size() || expGrp[retireCount] != grp) begin
                reportGroup(grp);
            end
        end
    endtask

    // Retire outputs are registered, so they are steady at the falling edge
    always @(negedge clk) begin
        if (!reset && retire.valid) begin
            checkRetire();
        end
    end

    // Program words go straight into the instruction memory as they are read
    task automatic loadTrace();
        int                fd;
        int                n;
        int                grp;
        string             line;
        rvIsa_pkg::wordT   idx;
        rvIsa_pkg::wordT   word;
        rvIsa_pkg::regIdxT rd;
        rvIsa_pkg::wordT   val;
        fd = $fopen("rvCore_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: the trace file rvCore_trace.txt could not be opened");
            errorCount++;
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] == "P") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%d", pauseAt);
            end else if (n > 0 && line[0] == "I") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%d %h %d %d %h",
                            idx, word, grp, rd, val);
                if (n != 5) begin
                    $display("Error: malformed trace line: %s", line);
                    errorCount++;
                end else begin
                    @(negedge clk);
                    progLoad.we   = 1'b1;
                    progLoad.addr = idx;
                    progLoad.data = word;
                    // rd of zero marks an instruction that must not retire
                    if (rd != '0) begin
                        expRd.push_back(rd);
                        expVal.push_back(val);
                        expGrp.push_back(grp);
                    end
                end
            end
        end
        $fclose(fd);
        @(negedge clk);
        progLoad.we = 1'b0;
    endtask

    task automatic waitForRetires(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (retireCount < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (retireCount < target) begin
            $display("Error at %0t: no retire arrived in time, %0d of %0d seen",
                     $time, retireCount, target);
            errorCount++;
            aborted = 1'b1;
        end
    endtask

    // Drop run, let the pipeline drain, then expect silence
    task automatic pauseRun();
        int quiet;
        int cycles;
        int heldCount;
        @(negedge clk);
        run = 1'b0;
        quiet = 0;
        cycles = 0;
        heldCount = retireCount;
        while (quiet < 4 && cycles < 16) begin
            @(posedge clk);
            cycles++;
            if (retireCount == heldCount) begin
                quiet++;
            end else begin
                quiet = 0;
                heldCount = retireCount;
            end
        end
        if (quiet < 4) begin
            $display("Error at %0t: core still retiring %0d cycles after run dropped",
                     $time, cycles);
            errorCount++;
            groupErr[PAUSE_GROUP]++;
        end
        heldCount = retireCount;
        repeat (20) @(posedge clk);
        checkCount++;
        if (retireCount != heldCount) begin
            $display("Error at %0t: %0d retires appeared while run was low",
                     $time, retireCount - heldCount);
            errorCount++;
            groupErr[PAUSE_GROUP]++;
        end
        // Part of the program is still unfetched while halted
        checkCount++;
        if (retireCount >= expRd.size()) begin
            $display("Error at %0t: fetch did not stop while run was low", $time);
            errorCount++;
            groupErr[PAUSE_GROUP]++;
        end
        @(negedge clk);
        run = 1'b1;
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        run      = 1'b0;
        progLoad = '0;
        aborted  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        loadTrace();
        if (!aborted) begin
            run = 1'b1;
            waitForRetires(pauseAt, MAX_WAIT);
        end
        if (!aborted) begin
            pauseRun();
            waitForRetires(expRd.size(), MAX_WAIT);
        end
        // Short tail so a late or repeated retire is still caught
        if (!aborted) begin
            repeat (10) @(posedge clk);
        end
        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (!aborted && errorCount == 0 && testsFailed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: rvCore_trace.txt
# I: word index, instruction (hex), test group, expected rd (0 = no retire), expected value (hex)
# P: retire count after which run is dropped
I 0 00500093 1 1 00000005
I 1 FFD00113 1 2 FFFFFFFD
I 2 002081B3 1 3 00000002
I 3 40208233 1 4 00000008
I 4 0020F2B3 1 5 00000005
I 5 0020E333 1 6 FFFFFFFD
I 6 0020C3B3 1 7 FFFFFFF8
I 7 00112433 1 8 00000001
I 8 FF608513 2 10 FFFFFFFB
I 9 FF017593 2 11 FFFFFFF0
I 10 F000E613 2 12 FFFFFF05
I 11 FFF0C693 2 13 FFFFFFFA
I 12 FFE12713 2 14 00000001
I 13 00100813 3 16 00000001
I 14 010808B3 3 17 00000002
I 15 01088933 3 18 00000003
I 16 011909B3 3 19 00000005
I 17 04000A93 4 21 00000040
I 18 007AA423 4 0 00000000
I 19 008AAB03 4 22 FFFFFFF8
I 20 001B0BB3 4 23 FFFFFFFD
I 21 00700013 5 0 00000000
I 22 12345C37 5 0 00000000
I 23 00100C33 5 24 00000005
P 21
I 24 064C0C93 6 25 00000069
I 25 002CCD33 6 26 FFFFFF94
I 26 008AAD83 6 27 FFFFFFF8
I 27 019DAE33 6 28 00000001
I 28 FFFE0E93 6 29 00000000
I 29 019D6F33 6 30 FFFFFFFD

// File: rvIsa_pkg.sv
package rvIsa_pkg;

    // Data and address word
    typedef logic [31:0] wordT;

    // Architectural register index
    typedef logic [4:0] regIdxT;

    // Instruction fields
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;

    // Major opcodes of the supported subset
    localparam opcodeT OP_REG   = 7'b0110011;
    localparam opcodeT OP_IMM   = 7'b0010011;
    localparam opcodeT OP_LOAD  = 7'b0000011;
    localparam opcodeT OP_STORE = 7'b0100011;

    // funct3 codes shared by OP_REG and OP_IMM
    localparam funct3T F3_ADD = 3'b000;
    localparam funct3T F3_SLT = 3'b010;
    localparam funct3T F3_XOR = 3'b100;
    localparam funct3T F3_OR  = 3'b110;
    localparam funct3T F3_AND = 3'b111;

    // Word access for LW and SW
    localparam funct3T F3_WORD = 3'b010;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrc;
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
    } ctrlT;

endpackage

// File: rvPipe_pkg.sv
package rvPipe_pkg;

    typedef struct packed {
        logic            valid;
        rvIsa_pkg::wordT pc;
        rvIsa_pkg::wordT instr;
    } ifIdT;

    typedef struct packed {
        logic              valid;
        rvIsa_pkg::ctrlT   ctrl;
        rvIsa_pkg::regIdxT rs1;
        rvIsa_pkg::regIdxT rs2;
        rvIsa_pkg::regIdxT rd;
        rvIsa_pkg::wordT   op1;
        rvIsa_pkg::wordT   op2;
        rvIsa_pkg::wordT   imm;
    } idExT;

    typedef struct packed {
        logic              valid;
        logic              regWrite;
        logic              memRead;
        logic              memWrite;
        rvIsa_pkg::regIdxT rd;
        rvIsa_pkg::wordT   aluResult;
        rvIsa_pkg::wordT   storeData;
    } exMemT;

    // MEM/WB contents, also the register write port and second forward source
    typedef struct packed {
        logic              valid;
        logic              regWrite;
        rvIsa_pkg::regIdxT rd;
        rvIsa_pkg::wordT   value;
    } wbT;

    typedef struct packed {
        logic              valid;
        rvIsa_pkg::regIdxT rd;
        rvIsa_pkg::wordT   value;
    } retireT;

    // Instruction memory load, addr is a word index
    typedef struct packed {
        logic            we;
        rvIsa_pkg::wordT addr;
        rvIsa_pkg::wordT data;
    } progLoadT;

endpackage
